// ==== dv/systolic_stimulus.txt ====
// one case per block of three lines, row-major, element [r][c] at position r*4+c
// line 1 is A, line 2 is B, line 3 is the expected C = A * B
// case 0: B is the identity
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
// case 1: largest operands
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
3f804 3f804 3f804 3f804 3f804 3f804 3f804 3f804 3f804 3f804 3f804 3f804 3f804 3f804 3f804 3f804
// case 2
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
01 00 02 00 00 01 00 02 03 00 01 00 00 03 00 01
0a 0e 05 08 1a 1e 11 14 2a 2e 1d 20 3a 3e 29 2c
// case 3
10 20 30 40 00 00 00 00 ff 01 00 00 02 03 05 07
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
5a0 640 6e0 780 0 0 0 0 104 204 304 404 99 aa bb cc

// ==== files.f ====
hw/systolic_pkg.sv
hw/operand_fifo.sv
hw/mac_pe.sv
hw/systolic_array.sv
hw/systolic_ctrl.sv
hw/systolic_regs.sv
hw/systolic_top.sv
dv/systolic_checker.sv
dv/systolic_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the systolic testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module systolic_tb -f files.f -o systolic_sim
./obj_dir/systolic_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== dv/systolic_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_tb;

  localparam int N          = systolic_pkg::SIZE;
  localparam int DW         = systolic_pkg::DATA_W;
  localparam int NUM_CASES  = 4;
  localparam int CASE_WORDS = 3 * N * N;
  localparam int CASE_BOUND = 200; // cycles per case.
  localparam int HOLD_CASE  = NUM_CASES - 1;
  localparam logic [7:0] UNMAPPED [5] = '{8'h08, 8'h3c, 8'h42, 8'h80, 8'hfc};

  logic          clk;
  logic          rst;
  logic [N*DW-1:0] x_data;
  logic          x_val;
  logic          x_rdy;
  logic [N*DW-1:0] w_data;
  logic          w_val;
  logic          w_rdy;
  logic          wb_cyc;
  logic          wb_stb;
  logic          wb_we;
  logic [7:0]    wb_adr;
  logic [31:0]   wb_wdata;
  logic [31:0]   wb_rdata;
  logic          wb_ack;
  logic          done;
  logic [31:0]   stim [NUM_CASES*CASE_WORDS];
  logic [31:0]   x_seed;
  logic [31:0]   w_seed;
  int            transfers;

  systolic_top uut (
    .clk      (clk),
    .rst      (rst),
    .x_data   (x_data),
    .x_val    (x_val),
    .x_rdy    (x_rdy),
    .w_data   (w_data),
    .w_val    (w_val),
    .w_rdy    (w_rdy),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .done     (done)
  );

  systolic_checker chk (
    .clk    (clk),
    .rst    (rst),
    .x_val  (x_val),
    .x_rdy  (x_rdy),
    .w_val  (w_val),
    .w_rdy  (w_rdy),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .done   (done)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (NUM_CASES * CASE_BOUND) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", NUM_CASES * CASE_BOUND);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // #################### wishbone master
  task automatic bus_transfer(input bit we, input logic [7:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
    int wait_cycles;
    wait_cycles = 0;
    rdata = '0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_wdata <= wdata;
    @(negedge clk);
    while (!wb_ack && wait_cycles < 16) begin
      wait_cycles++;
      @(negedge clk);
    end
    if (wb_ack)
      rdata = wb_rdata;
    else
      chk.report_failure("a wishbone transfer got no ack");
    transfers++;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_transfer(1'b1, adr, wdata, unused);
  endtask

  task automatic read_reg(input logic [7:0] adr, output logic [31:0] rdata);
    bus_transfer(1'b0, adr, 32'd0, rdata);
  endtask

  // #################### operand streams
  task automatic feed_x(input int base, input bit gaps, input bit hold);
    logic [N*DW-1:0] word;
    int idle;
    for (int k = 0; k < N; k++) begin
      idle = 0;
      if (gaps) begin
        x_seed = lcg_next(x_seed);
        idle   = int'(x_seed[29:28]);
      end
      x_val <= 1'b0;
      repeat (idle) @(posedge clk);
      for (int i = 0; i < N; i++)
        word[i*DW +: DW] = stim[base + i*N + k][DW-1:0]; // A[i][k] on lane i.
      x_data <= word;
      x_val  <= 1'b1;
      @(negedge clk);
      while (!x_rdy) @(negedge clk);
      @(posedge clk);
    end
    if (hold) begin
      x_data <= '1;
      x_val  <= 1'b1; // extra word held against full fifos.
    end else begin
      x_val <= 1'b0;
    end
  endtask

  task automatic feed_w(input int base, input bit gaps, input bit hold);
    logic [N*DW-1:0] word;
    int idle;
    for (int k = 0; k < N; k++) begin
      idle = 0;
      if (gaps) begin
        w_seed = lcg_next(w_seed);
        idle   = int'(w_seed[31:29]);
      end
      w_val <= 1'b0;
      repeat (idle) @(posedge clk);
      for (int j = 0; j < N; j++)
        word[j*DW +: DW] = stim[base + N*N + k*N + j][DW-1:0]; // B[k][j] on lane j.
      w_data <= word;
      w_val  <= 1'b1;
      @(negedge clk);
      while (!w_rdy) @(negedge clk);
      @(posedge clk);
    end
    if (hold) begin
      w_data <= '1;
      w_val  <= 1'b1;
    end else begin
      w_val <= 1'b0;
    end
  endtask

  task automatic run_case(input int c);
    int base;
    int polls;
    logic [31:0] rdata;
    base = c * CASE_WORDS;
    @(posedge clk);
    fork
      feed_x(base, c != 0, c == HOLD_CASE);
      begin
        if (c == NUM_CASES - 1)
          repeat (20) @(posedge clk); // w trails far behind x.
        feed_w(base, c != 0, c == HOLD_CASE);
      end
    join
    write_reg(systolic_pkg::REG_CTRL, 32'd1); // too early, must be ignored.
    rdata = '0;
    polls = 0;
    while (rdata != 32'(systolic_pkg::ST_DONE) && polls < 64) begin
      read_reg(systolic_pkg::REG_STATUS, rdata);
      polls++;
    end
    if (rdata != 32'(systolic_pkg::ST_DONE))
      chk.report_failure($sformatf("case %0d never reached the done phase", c));
    @(negedge clk);
    chk.expect_eq("done", 32'(done), 32'd1);
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        read_reg(systolic_pkg::REG_RESULT_BASE + 8'(4 * (i * N + j)), rdata);
        chk.expect_eq($sformatf("wb_rdata C[%0d][%0d]", i, j), rdata,
                      stim[base + 2*N*N + i*N + j]);
      end
    end
    if (c == HOLD_CASE) begin
      chk.expect_eq("x handshakes after done", chk.x_hs, 32'd0);
      chk.expect_eq("w handshakes after done", chk.w_hs, 32'd0);
      x_val <= 1'b0;
      w_val <= 1'b0;
    end
    write_reg(systolic_pkg::REG_CTRL, 32'd1);
    read_reg(systolic_pkg::REG_STATUS, rdata);
    chk.expect_eq("status after restart", rdata, 32'(systolic_pkg::ST_LOAD));
    @(negedge clk);
    chk.expect_eq("done", 32'(done), 32'd0);
  endtask

  // #################### main sequence
  initial begin
    int fd;
    logic [31:0] rdata;
    rst      <= 1'b1;
    x_data   <= '0;
    x_val    <= 1'b0;
    w_data   <= '0;
    w_val    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_wdata <= '0;
    x_seed    = 32'h2d06_3d41;
    w_seed    = lcg_next(32'h2d06_3d41);
    transfers = 0;
    fd = $fopen("dv/systolic_stimulus.txt", "r");
    if (fd == 0)
      chk.report_failure("cannot open the stimulus file dv/systolic_stimulus.txt");
    else
      $fclose(fd);
    $readmemh("dv/systolic_stimulus.txt", stim);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    chk.expect_eq("done", 32'(done), 32'd0);
    chk.expect_eq("wb_ack", 32'(wb_ack), 32'd0);
    chk.expect_eq("x_rdy", 32'(x_rdy), 32'd1);
    chk.expect_eq("w_rdy", 32'(w_rdy), 32'd1);
    read_reg(systolic_pkg::REG_STATUS, rdata);
    chk.expect_eq("status after reset", rdata, 32'(systolic_pkg::ST_LOAD));
    foreach (UNMAPPED[a]) begin
      read_reg(UNMAPPED[a], rdata);
      chk.expect_eq($sformatf("wb_rdata at 0x%h", UNMAPPED[a]), rdata, 32'd0);
    end
    write_reg(8'h08, 32'hffff_ffff);
    read_reg(8'h08, rdata);
    chk.expect_eq("wb_rdata after unmapped write", rdata, 32'd0);
    for (int c = 0; c < NUM_CASES; c++)
      run_case(c);
    chk.expect_eq("wb_ack count", chk.ack_count, transfers);
    $display("checks %0d, errors %0d, wishbone transfers %0d",
             chk.check_count, chk.error_count, transfers);
    if (chk.error_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/systolic_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_checker (
  input wire logic clk,
  input wire logic rst,
  input wire logic x_val,
  input wire logic x_rdy,
  input wire logic w_val,
  input wire logic w_rdy,
  input wire logic wb_cyc,
  input wire logic wb_stb,
  input wire logic wb_ack,
  input wire logic done
);

  int error_count;
  int check_count;
  int ack_count;
  int x_hs;
  int w_hs;
  bit ack_q;
  bit done_q;

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("failure: %s", what);
  endtask

  // #################### bus and stream monitor
  // inputs only change on the rising edge, so the falling edge sees them settled.
  always @(negedge clk) begin
    if (rst) begin
      x_hs   = 0;
      w_hs   = 0;
      ack_q  = 1'b0;
      done_q = 1'b0;
    end else begin
      if (x_val && x_rdy)
        x_hs++; // accepted on the next edge.
      if (w_val && w_rdy)
        w_hs++;
      if (done && (x_rdy || w_rdy))
        report_failure("a stream ready is high while the engine is done");
      if (done && !done_q) begin
        expect_eq("x handshakes per case", x_hs, systolic_pkg::SIZE);
        expect_eq("w handshakes per case", w_hs, systolic_pkg::SIZE);
        x_hs = 0;
        w_hs = 0;
      end
      if (wb_ack) begin
        ack_count++;
        if (ack_q)
          report_failure("wishbone ack stayed high for two cycles");
        if (!(wb_cyc && wb_stb))
          report_failure("wishbone ack came without a cycle in progress");
      end
      ack_q  = wb_ack;
      done_q = done;
    end
  end

endmodule

`default_nettype wire

// ==== hw/systolic_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_top (
  input  wire logic                                                 clk,
  input  wire logic                                                 rst,
  input  wire logic [systolic_pkg::SIZE*systolic_pkg::DATA_W-1:0]   x_data,
  input  wire logic                                                 x_val,
  output logic                                                      x_rdy,
  input  wire logic [systolic_pkg::SIZE*systolic_pkg::DATA_W-1:0]   w_data,
  input  wire logic                                                 w_val,
  output logic                                                      w_rdy,
  input  wire logic                                                 wb_cyc,
  input  wire logic                                                 wb_stb,
  input  wire logic                                                 wb_we,
  input  wire logic [systolic_pkg::WB_ADR_W-1:0]                    wb_adr,
  input  wire logic [systolic_pkg::WB_DAT_W-1:0]                    wb_wdata,
  output logic      [systolic_pkg::WB_DAT_W-1:0]                    wb_rdata,
  output logic                                                      wb_ack,
  output logic                                                      done
);

  localparam int N  = systolic_pkg::SIZE;
  localparam int DW = systolic_pkg::DATA_W;

  logic [N-1:0]                            x_fifo_full;
  logic [N-1:0]                            x_fifo_empty;
  logic [N-1:0]                            w_fifo_full;
  logic [N-1:0]                            w_fifo_empty;
  logic [N-1:0]                            x_fifo_wen;
  logic [N-1:0]                            w_fifo_wen;
  logic [N-1:0]                            x_fifo_ren;
  logic [N-1:0]                            w_fifo_ren;
  logic [N*DW-1:0]                         x_col;
  logic [N*DW-1:0]                         w_row;
  logic [N*N*systolic_pkg::ACC_W-1:0]      acc;
  logic                                    mac_en;
  logic                                    clear;
  logic                                    restart;
  systolic_pkg::ctrl_state_e               state;

  // #################### operand fifos
  genvar i;
  generate
    for (i = 0; i < N; i++) begin : g_lane
      operand_fifo u_x_fifo (
        .clk   (clk),
        .rst   (rst),
        .wen   (x_fifo_wen[i]),
        .wdata (x_data[i*DW +: DW]),
        .ren   (x_fifo_ren[i]),
        .rdata (x_col[i*DW +: DW]), // row i, left edge.
        .full  (x_fifo_full[i]),
        .empty (x_fifo_empty[i])
      );

      operand_fifo u_w_fifo (
        .clk   (clk),
        .rst   (rst),
        .wen   (w_fifo_wen[i]),
        .wdata (w_data[i*DW +: DW]),
        .ren   (w_fifo_ren[i]),
        .rdata (w_row[i*DW +: DW]), // column i, top edge.
        .full  (w_fifo_full[i]),
        .empty (w_fifo_empty[i])
      );
    end
  endgenerate

  // #################### grid and control
  systolic_array u_array (
    .clk    (clk),
    .rst    (rst),
    .mac_en (mac_en),
    .clear  (clear),
    .x_col  (x_col),
    .w_row  (w_row),
    .acc    (acc)
  );

  systolic_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .x_val        (x_val),
    .x_rdy        (x_rdy),
    .w_val        (w_val),
    .w_rdy        (w_rdy),
    .x_fifo_full  (x_fifo_full),
    .x_fifo_empty (x_fifo_empty),
    .w_fifo_full  (w_fifo_full),
    .w_fifo_empty (w_fifo_empty),
    .x_fifo_wen   (x_fifo_wen),
    .w_fifo_wen   (w_fifo_wen),
    .x_fifo_ren   (x_fifo_ren),
    .w_fifo_ren   (w_fifo_ren),
    .restart      (restart),
    .mac_en       (mac_en),
    .clear        (clear),
    .state        (state),
    .done         (done)
  );

  systolic_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .state    (state),
    .acc      (acc),
    .restart  (restart)
  );

endmodule

`default_nettype wire

// ==== hw/systolic_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_regs (
  input  wire logic                                                          clk,
  input  wire logic                                                          rst,
  input  wire logic                                                          wb_cyc,
  input  wire logic                                                          wb_stb,
  input  wire logic                                                          wb_we,
  input  wire logic [systolic_pkg::WB_ADR_W-1:0]                             wb_adr,
  input  wire logic [systolic_pkg::WB_DAT_W-1:0]                             wb_wdata,
  output logic      [systolic_pkg::WB_DAT_W-1:0]                             wb_rdata,
  output logic                                                               wb_ack,
  input  wire systolic_pkg::ctrl_state_e                                     state,
  input  wire logic [systolic_pkg::SIZE*systolic_pkg::SIZE*systolic_pkg::ACC_W-1:0] acc,
  output logic                                                               restart
);

  localparam int AW = systolic_pkg::WB_ADR_W;
  localparam int DW = systolic_pkg::WB_DAT_W;

  logic          req;
  logic          res_hit;
  logic [AW-1:0] res_off;
  logic [AW-3:0] res_idx;
  logic [DW-1:0] rd_mux;

  // new request only while ack is low, so ack stays a single pulse.
  assign req = wb_cyc & wb_stb & ~wb_ack;

  // #################### decode
  assign res_off = wb_adr - systolic_pkg::REG_RESULT_BASE;
  assign res_idx = res_off[AW-1:2];
  assign res_hit = (wb_adr >= systolic_pkg::REG_RESULT_BASE) &&
                   (res_off < AW'(systolic_pkg::RESULT_SPAN)) &&
                   (res_off[1:0] == 2'b00);

  always_comb begin
    rd_mux = '0; // unmapped reads as zero.
    if (wb_adr == systolic_pkg::REG_STATUS)
      rd_mux = DW'(state);
    else if (res_hit)
      rd_mux = DW'(acc[res_idx*systolic_pkg::ACC_W +: systolic_pkg::ACC_W]);
  end

  // #################### bus response
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack  <= 1'b0;
      restart <= 1'b0;
    end else begin
      wb_ack  <= req;
      restart <= req & wb_we &
                 (wb_adr == systolic_pkg::REG_CTRL) &
                 wb_wdata[systolic_pkg::CTRL_RESTART_BIT] &
                 (state == systolic_pkg::ST_DONE); // ignored in other phases.
    end
  end

  always_ff @(posedge clk) begin
    wb_rdata <= (req & ~wb_we) ? rd_mux : '0;
  end

endmodule

`default_nettype wire

// ==== hw/systolic_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_ctrl (
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire logic                              x_val,
  output logic                                   x_rdy,
  input  wire logic                              w_val,
  output logic                                   w_rdy,
  input  wire logic [systolic_pkg::SIZE-1:0]     x_fifo_full,
  input  wire logic [systolic_pkg::SIZE-1:0]     x_fifo_empty,
  input  wire logic [systolic_pkg::SIZE-1:0]     w_fifo_full,
  input  wire logic [systolic_pkg::SIZE-1:0]     w_fifo_empty,
  output logic      [systolic_pkg::SIZE-1:0]     x_fifo_wen,
  output logic      [systolic_pkg::SIZE-1:0]     w_fifo_wen,
  output logic      [systolic_pkg::SIZE-1:0]     x_fifo_ren,
  output logic      [systolic_pkg::SIZE-1:0]     w_fifo_ren,
  input  wire logic                              restart,
  output logic                                   mac_en,
  output logic                                   clear,
  output systolic_pkg::ctrl_state_e              state,
  output logic                                   done
);

  localparam int N = systolic_pkg::SIZE;

  logic                                 all_full;
  logic                                 all_empty;
  logic                                 in_load;
  logic                                 in_mac;
  logic [N-1:0]                         rd_en;
  logic [systolic_pkg::FLUSH_CNT_W-1:0] flush_cnt;

  // #################### status
  assign all_full  = (&x_fifo_full) & (&w_fifo_full);
  assign all_empty = (&x_fifo_empty) & (&w_fifo_empty);
  assign in_load   = (state == systolic_pkg::ST_LOAD);
  assign in_mac    = (state == systolic_pkg::ST_MAC);

  // #################### phase machine
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= systolic_pkg::ST_LOAD;
      flush_cnt <= '0;
    end else begin
      flush_cnt <= '0;
      case (state)
        systolic_pkg::ST_LOAD: if (all_full) state <= systolic_pkg::ST_MAC;
        systolic_pkg::ST_MAC:  if (all_empty) state <= systolic_pkg::ST_OUT;
        systolic_pkg::ST_OUT: begin
          if (flush_cnt == systolic_pkg::FLUSH_CNT_W'(systolic_pkg::FLUSH_CYCLES - 1))
            state <= systolic_pkg::ST_DONE;
          else
            flush_cnt <= flush_cnt + 1'b1; // drain skewed operands.
        end
        systolic_pkg::ST_DONE: if (restart) state <= systolic_pkg::ST_LOAD;
        default: state <= systolic_pkg::ST_LOAD;
      endcase
    end
  end

  // #################### streams
  assign x_rdy      = in_load & ~(|x_fifo_full);
  assign w_rdy      = in_load & ~(|w_fifo_full);
  assign x_fifo_wen = {N{x_val & x_rdy}};
  assign w_fifo_wen = {N{w_val & w_rdy}};

  // #################### skewed reads
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en <= '0;
    end else begin
      rd_en[0] <= (in_load & all_full) | (in_mac & ~all_empty);
      for (int i = 1; i < N; i++)
        rd_en[i] <= in_mac & rd_en[i-1]; // one cycle per lane.
    end
  end

  assign x_fifo_ren = rd_en;
  assign w_fifo_ren = rd_en;

  assign mac_en = in_mac | (state == systolic_pkg::ST_OUT);
  assign done   = (state == systolic_pkg::ST_DONE);
  assign clear  = restart & done;

endmodule

`default_nettype wire

// ==== hw/systolic_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_array (
  input  wire logic                                                          clk,
  input  wire logic                                                          rst,
  input  wire logic                                                          mac_en,
  input  wire logic                                                          clear,
  input  wire logic [systolic_pkg::SIZE*systolic_pkg::DATA_W-1:0]            x_col,
  input  wire logic [systolic_pkg::SIZE*systolic_pkg::DATA_W-1:0]            w_row,
  output logic [systolic_pkg::SIZE*systolic_pkg::SIZE*systolic_pkg::ACC_W-1:0] acc
);

  localparam int N  = systolic_pkg::SIZE;
  localparam int DW = systolic_pkg::DATA_W;
  localparam int AW = systolic_pkg::ACC_W;

  // x_h[i][j] enters PE(i,j) from the left, w_v[i][j] from above.
  logic [DW-1:0] x_h [N][N+1];
  logic [DW-1:0] w_v [N+1][N];

  genvar i, j;

  generate
    for (i = 0; i < N; i++) begin : g_edge
      assign x_h[i][0] = x_col[i*DW +: DW];
      assign w_v[0][i] = w_row[i*DW +: DW];
    end

    for (i = 0; i < N; i++) begin : g_row
      for (j = 0; j < N; j++) begin : g_col
        mac_pe u_pe (
          .clk    (clk),
          .rst    (rst),
          .mac_en (mac_en),
          .clear  (clear),
          .x_in   (x_h[i][j]),
          .w_in   (w_v[i][j]),
          .x_out  (x_h[i][j+1]),
          .w_out  (w_v[i+1][j]),
          .acc    (acc[(i*N+j)*AW +: AW]) // slot i*SIZE+j.
        );
      end
    end
  endgenerate

endmodule

`default_nettype wire

// ==== hw/mac_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_pe (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             mac_en,
  input  wire logic                             clear,
  input  wire logic [systolic_pkg::DATA_W-1:0]  x_in,
  input  wire logic [systolic_pkg::DATA_W-1:0]  w_in,
  output logic      [systolic_pkg::DATA_W-1:0]  x_out,
  output logic      [systolic_pkg::DATA_W-1:0]  w_out,
  output logic      [systolic_pkg::ACC_W-1:0]   acc
);

  logic [systolic_pkg::ACC_W-1:0] prod;

  assign prod = systolic_pkg::ACC_W'(x_in) * systolic_pkg::ACC_W'(w_in);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      x_out <= '0;
      w_out <= '0;
      acc   <= '0;
    end else begin
      x_out <= x_in; // one hop right.
      w_out <= w_in; // one hop down.
      if (mac_en)
        acc <= acc + prod;
    end
  end

endmodule

`default_nettype wire

// ==== hw/operand_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fifo (
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire logic                              wen,
  input  wire logic [systolic_pkg::DATA_W-1:0]   wdata,
  input  wire logic                              ren,
  output logic      [systolic_pkg::DATA_W-1:0]   rdata,
  output logic                                   full,
  output logic                                   empty
);

  logic [systolic_pkg::DATA_W-1:0] mem [systolic_pkg::SIZE];
  logic [systolic_pkg::PTR_W-1:0]  wr_ptr;
  logic [systolic_pkg::PTR_W-1:0]  rd_ptr;
  logic [systolic_pkg::CNT_W-1:0]  count;
  logic                            do_wr;
  logic                            do_rd;

  assign full  = (count == systolic_pkg::CNT_W'(systolic_pkg::SIZE));
  assign empty = (count == '0);
  assign do_wr = wen & ~full;
  assign do_rd = ren & ~empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= (wr_ptr == systolic_pkg::PTR_W'(systolic_pkg::SIZE - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == systolic_pkg::PTR_W'(systolic_pkg::SIZE - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr)
      mem[wr_ptr] <= wdata;
    rdata <= do_rd ? mem[rd_ptr] : '0; // idle lanes feed zeros.
  end

endmodule

`default_nettype wire

// ==== hw/systolic_pkg.sv ====
`default_nettype none

package systolic_pkg;

  // #################### sizes
  localparam int SIZE         = 4;
  localparam int DATA_W       = 8;
  localparam int ACC_W        = 20; // room for SIZE 16-bit products.
  localparam int FLUSH_CYCLES = 2 * SIZE;
  localparam int FLUSH_CNT_W  = $clog2(FLUSH_CYCLES);
  localparam int PTR_W        = $clog2(SIZE);
  localparam int CNT_W        = $clog2(SIZE + 1);

  // #################### wishbone
  localparam int WB_ADR_W = 8;
  localparam int WB_DAT_W = 32;

  localparam logic [WB_ADR_W-1:0] REG_STATUS      = 8'h00;
  localparam logic [WB_ADR_W-1:0] REG_CTRL        = 8'h04;
  localparam logic [WB_ADR_W-1:0] REG_RESULT_BASE = 8'h40; // C[i][j] at +4*(i*SIZE+j).
  localparam int                  RESULT_SPAN     = 4 * SIZE * SIZE;

  localparam int CTRL_RESTART_BIT = 0;

  // #################### controller phases
  typedef enum logic [1:0] {
    ST_LOAD = 2'd0,
    ST_MAC  = 2'd1,
    ST_OUT  = 2'd2,
    ST_DONE = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire
